//--- design/zbus_settings.svh
/*
 * Z80 sound bus subsystem
 * Widths, address windows and the open-bus value shared by the design
 */
`ifndef ZBUS_SETTINGS_SVH
`define ZBUS_SETTINGS_SVH

// Bus widths
`define ZBUS_MAIN_ADDR_W 24
`define ZBUS_MAIN_DATA_W 16
`define ZBUS_Z80_ADDR_W 16
`define ZBUS_BYTE_W 8
`define ZBUS_ADDR_W 15
`define ZRAM_ADDR_W 13
`define ZBUS_BANK_W 9

// Value returned for unmapped or unavailable space
`define ZBUS_OPEN_BUS 8'hFF

// Main bus decode
`define ZBUS_MAIN_WIN 8'hA0
`define ZBUS_CTRL_BUSREQ 24'hA11100
`define ZBUS_CTRL_RESET 24'hA11200

// Z80 page 6000-60FF holds the bank register
`define ZBUS_BANK_PAGE 7'h60

`endif

//--- design/zbus_pkg.sv
/*
 * Z80 sound bus types
 * Request and response records for both requesters, control register
 * write record and the arbiter enums
 */
`include "zbus_settings.svh"

package zbus_pkg;

	// ------------------------------------------------
	// Main (68000 side) bus
	// ------------------------------------------------
	typedef struct packed {
		logic                          valid;
		logic                          write;
		logic [`ZBUS_MAIN_ADDR_W-1:0]  addr;
		logic                          uds_n;
		logic                          lds_n;
		logic [`ZBUS_MAIN_DATA_W-1:0]  wdata;
	} main_req_t;

	typedef struct packed {
		logic                          ack;
		logic [`ZBUS_MAIN_DATA_W-1:0]  rdata;
	} main_rsp_t;

	// ------------------------------------------------
	// Z80 side bus
	// ------------------------------------------------
	typedef struct packed {
		logic                          valid;
		logic                          write;
		logic [`ZBUS_Z80_ADDR_W-1:0]   addr;
		logic [`ZBUS_BYTE_W-1:0]       wdata;
	} z80_req_t;

	typedef struct packed {
		logic                          ack;
		logic [`ZBUS_BYTE_W-1:0]       rdata;
	} z80_rsp_t;

	// Write strobe into the bus request / reset registers
	typedef struct packed {
		logic we;
		logic sel_reset;
		logic bit8;
	} ctrl_wr_t;

	typedef enum logic {SRC_MAIN, SRC_Z80} zbus_src_e;

	typedef enum logic [1:0] {ZB_IDLE, ZB_READ, ZB_FINISH} zbus_state_e;

endpackage

//--- design/z80_ctrl_regs.sv
/*
 * Z80 control registers
 * Bus request and Z80 reset as seen from the main bus, with the
 * bus-free flag that lets the main side onto the Z80 bus
 */
`timescale 1ns/1ps

module z80_ctrl_regs (
	input  logic               MCLK,
	input  logic               reset,
	input  zbus_pkg::ctrl_wr_t ctrl_wr,
	output logic               z80_busreq_n,
	output logic               z80_reset_n,
	output logic               busak_n,
	output logic               zbus_free
);

	// ------------------------------------------------
	// Register writes
	// ------------------------------------------------
	// Bus request is written as active high data bit 8,
	// held inverted like the Z80 pin
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else if (ctrl_wr.we) begin
			if (ctrl_wr.sel_reset) begin
				z80_reset_n <= ctrl_wr.bit8;
			end else begin
				z80_busreq_n <= ~ctrl_wr.bit8;
			end
		end
	end

	// ------------------------------------------------
	// Status
	// ------------------------------------------------
	// Z80 is off the bus only while requested and out of reset
	assign zbus_free = ~z80_busreq_n & z80_reset_n;

	// Acknowledge as read back at A11100
	assign busak_n = ~zbus_free;

endmodule

//--- design/zram.sv
/*
 * Z80 work RAM
 * Byte wide single port memory, written on the clock, registered read
 */
`timescale 1ns/1ps

`include "zbus_settings.svh"

module zram #(
	parameter int ADDR_W = `ZRAM_ADDR_W
) (
	input  logic                    MCLK,
	input  logic [ADDR_W-1:0]       addr,
	input  logic                    we,
	input  logic [`ZBUS_BYTE_W-1:0] wdata,
	output logic [`ZBUS_BYTE_W-1:0] rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [`ZBUS_BYTE_W-1:0] mem [0:DEPTH-1];

	// Read returns the old byte when writing the same address
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- design/zbus_arbiter.sv
/*
 * Z80 bus arbiter
 * Idle/read/finish machine shared by the main bus and the Z80, with
 * address decode for both sides and the Z80 bank register
 */
`timescale 1ns/1ps

`include "zbus_settings.svh"

module zbus_arbiter (
	input  logic                     MCLK,
	input  logic                     reset,
	input  zbus_pkg::main_req_t      main_req,
	output zbus_pkg::main_rsp_t      main_rsp,
	input  zbus_pkg::z80_req_t       z80_req,
	output zbus_pkg::z80_rsp_t       z80_rsp,
	output zbus_pkg::ctrl_wr_t       ctrl_wr,
	input  logic                     zbus_free,
	input  logic                     busak_n,
	input  logic                     z80_reset_n,
	output logic [`ZRAM_ADDR_W-1:0]  ram_addr,
	output logic                     ram_we,
	output logic [`ZBUS_BYTE_W-1:0]  ram_wdata,
	input  logic [`ZBUS_BYTE_W-1:0]  ram_rdata,
	output logic [`ZBUS_BANK_W-1:0]  bank_addr
);

	import zbus_pkg::*;

	localparam logic [`ZBUS_BYTE_W-1:0] OPEN_BUS = `ZBUS_OPEN_BUS;

	zbus_state_e state;
	zbus_src_e   src;

	logic main_ack;
	logic z80_ack;
	logic [`ZBUS_MAIN_DATA_W-1:0] main_rdata;
	logic [`ZBUS_BYTE_W-1:0]      z80_rdata;

	// Decode of the incoming requests
	logic [`ZBUS_ADDR_W-1:0] main_int_addr;
	logic [`ZBUS_BYTE_W-1:0] main_wbyte;
	logic main_in_win;
	logic main_ram;
	logic main_is_busreq;
	logic main_is_reset;
	logic z80_ram;
	logic z80_bank;
	logic main_go;
	logic z80_go;

	// What the accepted request reads back
	logic rd_ram;
	logic rd_ctrl;
	logic ctrl_bit;
	logic [`ZBUS_BYTE_W-1:0]      rd_byte;
	logic [`ZBUS_MAIN_DATA_W-1:0] ctrl_word;

	// ------------------------------------------------
	// Address decode
	// ------------------------------------------------
	always_comb begin
		// Byte address on the Z80 bus
		// uds_n low selects the even byte
		main_int_addr  = {main_req.addr[14:1], main_req.uds_n};
		main_wbyte     = main_req.uds_n ? main_req.wdata[7:0] : main_req.wdata[15:8];
		main_in_win    = main_req.addr[`ZBUS_MAIN_ADDR_W-1 -: 8] == `ZBUS_MAIN_WIN;
		main_ram       = main_in_win & ~main_int_addr[14];
		main_is_busreq = main_req.addr == `ZBUS_CTRL_BUSREQ;
		main_is_reset  = main_req.addr == `ZBUS_CTRL_RESET;

		// RAM and its mirror at 0000-3FFF
		z80_ram  = z80_req.addr[15:14] == 2'b00;
		z80_bank = ~z80_req.addr[15] & (z80_req.addr[14:8] == `ZBUS_BANK_PAGE);
	end

	// Main wins when both are waiting
	assign main_go = (state == ZB_IDLE) & main_req.valid & ~main_ack;
	assign z80_go  = (state == ZB_IDLE) & z80_req.valid & ~z80_ack & ~main_go;

	// Control register write lands on the acceptance edge
	always_comb begin
		ctrl_wr.we        = main_go & main_req.write & (main_is_busreq | main_is_reset);
		ctrl_wr.sel_reset = main_is_reset;
		ctrl_wr.bit8      = main_req.wdata[8];
	end

	// ------------------------------------------------
	// State machine and handshake
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state     <= ZB_IDLE;
			src       <= SRC_MAIN;
			ram_we    <= 1'b0;
			main_ack  <= 1'b0;
			z80_ack   <= 1'b0;
			bank_addr <= '0;
		end else begin
			ram_we <= 1'b0;

			// Ack drops once the requester lets go of valid
			if (!main_req.valid) begin
				main_ack <= 1'b0;
			end
			if (!z80_req.valid) begin
				z80_ack <= 1'b0;
			end

			case (state)
				ZB_IDLE: begin
					if (main_go) begin
						src    <= SRC_MAIN;
						ram_we <= main_req.write & main_ram & zbus_free;
						state  <= ZB_READ;
					end else if (z80_go) begin
						src    <= SRC_Z80;
						ram_we <= z80_req.write & z80_ram;
						// Serial load of data bit 0 into the top bit
						if (z80_req.write && z80_bank) begin
							bank_addr <= {z80_req.wdata[0], bank_addr[`ZBUS_BANK_W-1:1]};
						end
						state <= ZB_READ;
					end
				end
				ZB_READ: begin
					state <= ZB_FINISH;
				end
				ZB_FINISH: begin
					if (src == SRC_MAIN) begin
						main_ack <= 1'b1;
					end else begin
						z80_ack <= 1'b1;
					end
					state <= ZB_IDLE;
				end
				default: begin
					state <= ZB_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------
	// Address, write data and read data
	// ------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (main_go) begin
			ram_addr  <= main_int_addr[`ZRAM_ADDR_W-1:0];
			ram_wdata <= main_wbyte;
			// Main side sees open bus while the Z80 owns it
			rd_ram    <= main_ram & zbus_free;
			rd_ctrl   <= main_is_busreq | main_is_reset;
			ctrl_bit  <= main_is_reset ? z80_reset_n : busak_n;
		end else if (z80_go) begin
			ram_addr  <= z80_req.addr[`ZRAM_ADDR_W-1:0];
			ram_wdata <= z80_req.wdata;
			rd_ram    <= z80_ram;
			rd_ctrl   <= 1'b0;
		end

		if (state == ZB_FINISH) begin
			if (src == SRC_MAIN) begin
				main_rdata <= rd_ctrl ? ctrl_word : {rd_byte, rd_byte};
			end else begin
				z80_rdata <= rd_byte;
			end
		end
	end

	assign rd_byte = rd_ram ? ram_rdata : OPEN_BUS;

	// Status on data bit 8 with the rest of the word high
	assign ctrl_word = {OPEN_BUS[7:1], ctrl_bit, OPEN_BUS};

	assign main_rsp = {main_ack, main_rdata};
	assign z80_rsp  = {z80_ack, z80_rdata};

endmodule

//--- design/zbus_top.sv
/*
 * Z80 sound bus subsystem top
 * Arbiter, Z80 work RAM and the bus request / reset registers
 */
`timescale 1ns/1ps

`include "zbus_settings.svh"

module zbus_top (
	input  logic                    MCLK,
	input  logic                    reset,
	input  zbus_pkg::main_req_t     main_req,
	output zbus_pkg::main_rsp_t     main_rsp,
	input  zbus_pkg::z80_req_t      z80_req,
	output zbus_pkg::z80_rsp_t      z80_rsp,
	output logic                    z80_busreq_n,
	output logic                    z80_reset_n,
	output logic [`ZBUS_BANK_W-1:0] bank_addr
);

	import zbus_pkg::*;

	ctrl_wr_t ctrl_wr;
	logic     zbus_free;
	logic     busak_n;

	logic [`ZRAM_ADDR_W-1:0] ram_addr;
	logic                    ram_we;
	logic [`ZBUS_BYTE_W-1:0] ram_wdata;
	logic [`ZBUS_BYTE_W-1:0] ram_rdata;

	// ------------------------------------------------
	// Bus state machine
	// ------------------------------------------------
	zbus_arbiter u_arbiter (
		.MCLK        (MCLK),
		.reset       (reset),
		.main_req    (main_req),
		.main_rsp    (main_rsp),
		.z80_req     (z80_req),
		.z80_rsp     (z80_rsp),
		.ctrl_wr     (ctrl_wr),
		.zbus_free   (zbus_free),
		.busak_n     (busak_n),
		.z80_reset_n (z80_reset_n),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_wdata   (ram_wdata),
		.ram_rdata   (ram_rdata),
		.bank_addr   (bank_addr)
	);

	// 8 KB, mirrored twice in Z80 space
	zram #(
		.ADDR_W (`ZRAM_ADDR_W)
	) u_zram (
		.MCLK  (MCLK),
		.addr  (ram_addr),
		.we    (ram_we),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	z80_ctrl_regs u_ctrl_regs (
		.MCLK         (MCLK),
		.reset        (reset),
		.ctrl_wr      (ctrl_wr),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n),
		.busak_n      (busak_n),
		.zbus_free    (zbus_free)
	);

endmodule

//--- verif/zbus_tb_model.svh
/*
 * Reference model for the Z80 sound bus testbench
 * Work RAM image, bank shift register, control registers and compare tasks
 */
`ifndef ZBUS_TB_MODEL_SVH
`define ZBUS_TB_MODEL_SVH

logic [7:0]              model_mem [0:8191];
logic [`ZBUS_BANK_W-1:0] model_bank;
logic                    model_busreq_n;
logic                    model_reset_n;

// Main side may use the Z80 bus
function automatic logic bus_free_now();
	return ~model_busreq_n & model_reset_n;
endfunction

// Byte in the 8 KB RAM hit by a main window access
function automatic logic [12:0] ram_index_of_main(input logic [23:0] addr, input logic uds_n);
	return {addr[12:1], uds_n};
endfunction

// ------------------------------------------------
// Predicted read data
// ------------------------------------------------
function automatic logic [15:0] predict_main_read(input logic [23:0] addr, input logic uds_n);
	logic [7:0] b;
	if (addr == `ZBUS_CTRL_BUSREQ) begin
		return {7'h7F, ~bus_free_now(), 8'hFF};
	end
	if (addr == `ZBUS_CTRL_RESET) begin
		return {7'h7F, model_reset_n, 8'hFF};
	end
	if (addr[23:16] == `ZBUS_MAIN_WIN && !addr[14] && bus_free_now()) begin
		b = model_mem[ram_index_of_main(addr, uds_n)];
		return {b, b};
	end
	return 16'hFFFF;
endfunction

function automatic logic [7:0] predict_z80_read(input logic [15:0] addr);
	return (addr[15:14] == 2'b00) ? model_mem[addr[12:0]] : 8'hFF;
endfunction

// ------------------------------------------------
// Model updates
// ------------------------------------------------
task automatic apply_main_write(input logic [23:0] addr, input logic uds_n,
		input logic [15:0] wdata);
	if (addr == `ZBUS_CTRL_BUSREQ) begin
		model_busreq_n = ~wdata[8];
	end else if (addr == `ZBUS_CTRL_RESET) begin
		model_reset_n = wdata[8];
	end else if (addr[23:16] == `ZBUS_MAIN_WIN && !addr[14] && bus_free_now()) begin
		model_mem[ram_index_of_main(addr, uds_n)] = uds_n ? wdata[7:0] : wdata[15:8];
	end
endtask

task automatic apply_z80_write(input logic [15:0] addr, input logic [7:0] wdata);
	if (addr[15:14] == 2'b00) begin
		model_mem[addr[12:0]] = wdata;
	end else if (!addr[15] && addr[14:8] == `ZBUS_BANK_PAGE) begin
		// New bit enters at the top
		model_bank = {wdata[0], model_bank[`ZBUS_BANK_W-1:1]};
	end
endtask

// ------------------------------------------------
// Compare tasks
// ------------------------------------------------
task automatic check_main(input string name, input main_rsp_t exp, input main_rsp_t act);
	if (act !== exp) begin
		errors++;
		$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic check_z80(input string name, input z80_rsp_t exp, input z80_rsp_t act);
	if (act !== exp) begin
		errors++;
		$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic check_ctrl(input logic exp_busreq_n, input logic exp_reset_n);
	if (z80_busreq_n !== exp_busreq_n) begin
		errors++;
		$display("Error at %0t: z80_busreq_n expected %b, got %b", $time, exp_busreq_n,
			z80_busreq_n);
	end
	if (z80_reset_n !== exp_reset_n) begin
		errors++;
		$display("Error at %0t: z80_reset_n expected %b, got %b", $time, exp_reset_n,
			z80_reset_n);
	end
endtask

task automatic check_bank(input logic [`ZBUS_BANK_W-1:0] exp);
	if (bank_addr !== exp) begin
		errors++;
		$display("Error at %0t: bank_addr expected %h, got %h", $time, exp, bank_addr);
	end
endtask

`endif

//--- verif/zbus_tb.sv
/*
 * Testbench for the Z80 sound bus subsystem
 * Drives both requesters through the DTACK-like handshake and checks
 * read data, control registers and the bank register against a model
 */
`timescale 1ns/1ps

`include "zbus_settings.svh"

module zbus_tb;

	import zbus_pkg::*;

	localparam int N_MAIN_PAIRS   = 30;
	localparam int N_Z80_PAIRS    = 20;
	localparam int N_TRANS        = 124;
	localparam int TIMEOUT_CYCLES = 40 * N_TRANS + 200;

	logic                    MCLK;
	logic                    reset;
	main_req_t               main_req;
	main_rsp_t               main_rsp;
	z80_req_t                z80_req;
	z80_rsp_t                z80_rsp;
	logic                    z80_busreq_n;
	logic                    z80_reset_n;
	logic [`ZBUS_BANK_W-1:0] bank_addr;

	int errors;
	int cycles;
	int main_ack_cycle;
	int z80_ack_cycle;

	// Expected read data for the open transaction on each side
	logic      main_check;
	logic      z80_check;
	main_rsp_t main_exp;
	z80_rsp_t  z80_exp;
	logic      main_ack_q;
	logic      z80_ack_q;

	// RAM bytes with known contents
	logic [12:0] written [$];

	`include "zbus_tb_model.svh"

	zbus_top UUT (
		.MCLK         (MCLK),
		.reset        (reset),
		.main_req     (main_req),
		.main_rsp     (main_rsp),
		.z80_req      (z80_req),
		.z80_rsp      (z80_rsp),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n),
		.bank_addr    (bank_addr)
	);

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge MCLK);
			cycles++;
		end
		$display("Run timed out after %0d cycles, a handshake never completed", cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	// ------------------------------------------------
	// Compare on the rising ack of a read
	// ------------------------------------------------
	always @(negedge MCLK) begin
		if (main_rsp.ack === 1'b1 && !main_ack_q && main_check) begin
			check_main("main_rsp", main_exp, main_rsp);
		end
		if (z80_rsp.ack === 1'b1 && !z80_ack_q && z80_check) begin
			check_z80("z80_rsp", z80_exp, z80_rsp);
		end
		main_ack_q = (main_rsp.ack === 1'b1);
		z80_ack_q  = (z80_rsp.ack === 1'b1);
	end

	// Enters and returns 1 ns after a rising edge
	task automatic main_access(input logic write, input logic [23:0] addr,
			input logic uds_n, input logic [15:0] wdata);
		if (write) begin
			main_check = 1'b0;
			apply_main_write(addr, uds_n, wdata);
		end else begin
			main_check = 1'b1;
			main_exp   = {1'b1, predict_main_read(addr, uds_n)};
		end
		main_req.valid = 1'b1;
		main_req.write = write;
		main_req.addr  = addr;
		main_req.uds_n = uds_n;
		main_req.lds_n = ~uds_n;
		main_req.wdata = wdata;
		do begin
			@(posedge MCLK);
			#1;
		end while (main_rsp.ack !== 1'b1);
		main_ack_cycle = cycles;
		main_req.valid = 1'b0;
		do begin
			@(posedge MCLK);
			#1;
		end while (main_rsp.ack !== 1'b0);
	endtask

	task automatic z80_access(input logic write, input logic [15:0] addr,
			input logic [7:0] wdata);
		if (write) begin
			z80_check = 1'b0;
			apply_z80_write(addr, wdata);
		end else begin
			z80_check = 1'b1;
			z80_exp   = {1'b1, predict_z80_read(addr)};
		end
		z80_req.valid = 1'b1;
		z80_req.write = write;
		z80_req.addr  = addr;
		z80_req.wdata = wdata;
		do begin
			@(posedge MCLK);
			#1;
		end while (z80_rsp.ack !== 1'b1);
		z80_ack_cycle = cycles;
		z80_req.valid = 1'b0;
		do begin
			@(posedge MCLK);
			#1;
		end while (z80_rsp.ack !== 1'b0);
	endtask

	// Main window alias of a RAM byte with random bits 15 and 13
	function automatic logic [23:0] main_alias(input logic [12:0] ra);
		return {8'hA0, 1'($urandom), 1'b0, 1'($urandom), ra[12:1], 1'b0};
	endfunction

	function automatic logic [15:0] z80_alias(input logic [12:0] ra);
		return {2'b00, 1'($urandom), ra};
	endfunction

	function automatic logic [12:0] pick_written();
		return written[$urandom % written.size()];
	endfunction

	// ------------------------------------------------
	// Stimulus
	// ------------------------------------------------
	initial begin : stimulus
		logic [12:0] ra;
		logic [12:0] rb;
		logic [23:0] ma;
		logic [15:0] za;
		void'($urandom(32'h59b));
		errors         = 0;
		main_check     = 1'b0;
		z80_check      = 1'b0;
		main_ack_q     = 1'b0;
		z80_ack_q      = 1'b0;
		model_busreq_n = 1'b1;
		model_reset_n  = 1'b0;
		model_bank     = '0;
		main_req       = '0;
		z80_req        = '0;
		reset          = 1'b1;
		repeat (3) @(posedge MCLK);
		#1;
		reset = 1'b0;

		// Out of reset the Z80 owns the bus
		check_ctrl(1'b1, 1'b0);
		check_bank('0);
		main_access(1'b0, `ZBUS_CTRL_BUSREQ, 1'b0, 16'h0000);
		main_access(1'b0, `ZBUS_CTRL_RESET, 1'b0, 16'h0000);

		// Blocked main write leaves the byte seen by the Z80 unchanged
		ra = ram_index_of_main(24'hA00010, 1'b0);
		z80_access(1'b1, {3'b000, ra}, 8'h5A);
		written.push_back(ra);
		main_access(1'b1, 24'hA00010, 1'b0, 16'hC3C3);
		main_access(1'b0, 24'hA00010, 1'b0, 16'h0000);
		z80_access(1'b0, {3'b000, ra}, 8'h00);

		// Request the bus and then release the Z80 reset
		main_access(1'b1, `ZBUS_CTRL_BUSREQ, 1'b0, 16'h0100);
		main_access(1'b1, `ZBUS_CTRL_RESET, 1'b0, 16'h0100);
		check_ctrl(1'b0, 1'b1);
		main_access(1'b0, `ZBUS_CTRL_BUSREQ, 1'b0, 16'h0000);

		for (int i = 0; i < N_MAIN_PAIRS; i++) begin
			ra = 13'($urandom);
			main_access(1'b1, main_alias(ra), ra[0], 16'($urandom));
			written.push_back(ra);
			rb = pick_written();
			main_access(1'b0, main_alias(rb), rb[0], 16'h0000);
		end

		for (int i = 0; i < N_Z80_PAIRS; i++) begin
			ra = 13'($urandom);
			z80_access(1'b1, z80_alias(ra), 8'($urandom));
			written.push_back(ra);
			rb = pick_written();
			z80_access(1'b0, z80_alias(rb), 8'h00);
		end

		// Main write then Z80 read of the same byte
		ra = 13'($urandom);
		main_access(1'b1, main_alias(ra), ra[0], 16'($urandom));
		written.push_back(ra);
		z80_access(1'b0, z80_alias(ra), 8'h00);

		// Bank register takes one bit per write
		repeat (9) z80_access(1'b1, 16'h6000, 8'($urandom));
		check_bank(model_bank);
		z80_access(1'b0, 16'h4000, 8'h00);
		z80_access(1'b0, 16'h7000, 8'h00);

		// Both requesters in the same cycle
		ra = pick_written();
		rb = pick_written();
		ma = main_alias(ra);
		za = z80_alias(rb);
		fork
			main_access(1'b0, ma, ra[0], 16'h0000);
			z80_access(1'b0, za, 8'h00);
		join
		if (main_ack_cycle >= z80_ack_cycle) begin
			errors++;
			$display("Same-cycle requests were not served main first (main %0d, Z80 %0d)",
				main_ack_cycle, z80_ack_cycle);
		end

		repeat (2) @(posedge MCLK);
		$display("Run finished after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- zbus_top.f
+incdir+design
+incdir+verif
design/zbus_pkg.sv
design/z80_ctrl_regs.sv
design/zram.sv
design/zbus_arbiter.sv
design/zbus_top.sv
verif/zbus_tb.sv

//--- Makefile
# Verilator build and run for the Z80 sound bus testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= zbus_tb
FILELIST  ?= zbus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
